// ==== viterbi_eq.f ====
hdl/viterbi_pkg.sv
hdl/expectation_table.sv
hdl/branch_unit.sv
hdl/state_unit.sv
hdl/survivor_select.sv
hdl/viterbi_core.sv
bench/viterbi_core_properties.sv
bench/tb_viterbi_core.sv

// ==== run.sh ====
#!/bin/sh
# build and run the viterbi_core testbench with verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_viterbi_core \
    --Mdir obj_dir \
    -f viterbi_eq.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_viterbi_core
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi
exit 0

// ==== bench/tb_viterbi_core.sv ====
`timescale 1ns/1ps

module tb_viterbi_core
    import viterbi_pkg::*;
();

    localparam int B_WIDTH        = 8;
    localparam int H_DEPTH        = 8;
    localparam int TIMEOUT_CYCLES = 4000;

    logic                        clk;
    logic                        reset;
    logic signed [TAP_WIDTH-1:0] est_channel [CHAN_TAPS];
    logic                        update;
    logic signed [B_WIDTH-1:0]   sample;
    logic                        sample_valid;
    symbol_t                     decision;
    logic                        decision_valid;

    // channel model state, sent[k] is the symbol of sample k.
    int     taps [CHAN_TAPS];
    int     sent [$];
    integer seed;
    int     cycle_count;

    viterbi_core #(
        .B_WIDTH(B_WIDTH),
        .H_DEPTH(H_DEPTH)
    ) viterbi_core_inst (
        .clk(clk),
        .reset(reset),
        .est_channel(est_channel),
        .update(update),
        .sample(sample),
        .sample_valid(sample_valid),
        .decision(decision),
        .decision_valid(decision_valid)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout after %0d cycles, the tests did not finish", cycle_count);
        $display("Something failed");
        $fatal(1, "timeout");
    end

    task automatic check_value(input string test_name, input int expected, input int actual);
        if (expected !== actual) begin
            $display("mismatch in %s: expected %0d, actual %0d", test_name, expected, actual);
            $display("Something failed");
            $fatal(1, "value check failed");
        end
    endtask

    function automatic int random_symbol();
        return ($random(seed) & 1) ? -1 : 1;
    endfunction

    task automatic load_taps(input int t0, input int t1, input int t2);
        taps[0] = t0;
        taps[1] = t1;
        taps[2] = t2;
        for (int t = 0; t < CHAN_TAPS; t++) begin
            est_channel[t] = TAP_WIDTH'(taps[t]);
        end
        update = 1'b1;
        @(negedge clk);
        update = 1'b0;
        repeat (2) @(negedge clk);
    endtask

    // one sample through the channel model, then one idle cycle.
    task automatic send_symbol(input string test_name, input int sym, input int noise_bound,
                               input bit check_decision);
        int prev1;
        int prev2;
        int level;
        int k;
        // before any sample the channel holds the +1 preamble.
        prev1 = (sent.size() > 0) ? sent[$] : 1;
        prev2 = (sent.size() > 1) ? sent[$-1] : 1;
        level = taps[0] * sym + taps[1] * prev1 + taps[2] * prev2;
        if (noise_bound > 0) begin
            level = level + ($random(seed) % (noise_bound + 1));
        end
        sent.push_back(sym);
        k = sent.size() - 1;
        sample = B_WIDTH'(level);
        sample_valid = 1'b1;
        @(negedge clk);
        sample_valid = 1'b0;
        check_value(test_name, (k >= H_DEPTH) ? 1 : 0, int'(decision_valid));
        if (check_decision && k >= H_DEPTH) begin
            check_value(test_name, sent[k - H_DEPTH], int'(decision));
        end
        @(negedge clk);
        check_value(test_name, 0, int'(decision_valid));
    endtask

    task automatic idle_after_reset();
        repeat (12) begin
            @(negedge clk);
            check_value("idle_after_reset", 0, int'(decision_valid));
        end
    endtask

    task automatic warm_up();
        load_taps(40, 0, 0);
        repeat (2 * H_DEPTH) send_symbol("warm_up", 1, 0, 1'b1);
    endtask

    task automatic noise_free();
        load_taps(40, 20, -10);
        repeat (4) send_symbol("noise_free", 1, 0, 1'b1);
        repeat (64) send_symbol("noise_free", random_symbol(), 0, 1'b1);
    endtask

    task automatic noisy();
        repeat (64) send_symbol("noisy", random_symbol(), 5, 1'b1);
    endtask

    // decisions on symbols from before the update are not checked.
    task automatic channel_change();
        load_taps(30, -25, 12);
        repeat (8 + H_DEPTH) send_symbol("channel_change", 1, 0, 1'b0);
        repeat (48) send_symbol("channel_change", random_symbol(), 0, 1'b1);
    endtask

    initial begin
        seed = 32'h01f3_7e5a;
        reset = 1'b1;
        update = 1'b0;
        sample = '0;
        sample_valid = 1'b0;
        for (int t = 0; t < CHAN_TAPS; t++) begin
            est_channel[t] = '0;
            taps[t] = 0;
        end
        repeat (16) @(negedge clk);
        reset = 1'b0;
        idle_after_reset();
        warm_up();
        noise_free();
        noisy();
        channel_change();
        $display("Everything OK");
        $finish;
    end

endmodule

// ==== bench/viterbi_core_properties.sv ====
`timescale 1ns/1ps

module viterbi_core_properties
    import viterbi_pkg::*;
(
    input logic       clk,
    input logic       reset,
    input logic       sample_valid,
    input symbol_t    decision,
    input logic       decision_valid,
    input energy_t    min_energy,
    input state_rec_t states [NUM_STATES]
);

    logic min_ok;

    always_comb begin
        min_ok = 1'b1;
        for (int s = 0; s < NUM_STATES; s++) begin
            if (min_energy > states[s].energy) begin
                min_ok = 1'b0;
            end
        end
    end

    // quiet through reset and the first cycle out of it.
    assert property (@(posedge clk) reset |=> !decision_valid)
        else $error("decision_valid high right after a reset cycle");
    assert property (@(posedge clk) $fell(reset) |=> !decision_valid)
        else $error("decision_valid high in the cycle after reset");

    assert property (@(posedge clk) disable iff (reset) decision_valid |-> $past(sample_valid))
        else $error("decision_valid without a sample in the cycle before");

    assert property (@(posedge clk) disable iff (reset)
        decision_valid |-> (decision == SYM_POS || decision == SYM_NEG))
        else $error("decision is not a valid symbol");

    assert property (@(posedge clk) disable iff (reset) min_ok)
        else $error("min_energy above a state energy");

endmodule

bind viterbi_core viterbi_core_properties viterbi_core_properties_inst (
    .clk(clk),
    .reset(reset),
    .sample_valid(sample_valid),
    .decision(decision),
    .decision_valid(decision_valid),
    .min_energy(min_energy),
    .states(states)
);

// ==== hdl/viterbi_core.sv ====
`timescale 1ns/1ps

module viterbi_core
    import viterbi_pkg::*;
#(
    parameter int B_WIDTH = 8,
    parameter int H_DEPTH = 8
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic signed [TAP_WIDTH-1:0] est_channel [CHAN_TAPS],
    input  logic                        update,
    input  logic signed [B_WIDTH-1:0]   sample,
    input  logic                        sample_valid,
    output symbol_t                     decision,
    output logic                        decision_valid
);

    expect_t    expected [NUM_BRANCHES];
    state_rec_t states [NUM_STATES];
    // incoming candidates per destination, slot 0 from the lower branch.
    state_rec_t cand [NUM_STATES][2];
    energy_t    min_energy;

    expectation_table expectation_table_inst (
        .clk(clk),
        .reset(reset),
        .est_channel(est_channel),
        .update(update),
        .expected(expected)
    );

    for (genvar b = 0; b < NUM_BRANCHES; b++) begin : gen_branch
        localparam int SRC  = int'(branch_source(b));
        localparam int DST  = int'(branch_dest(b));
        localparam int SLOT = SRC % 2;

        branch_unit #(
            .B_WIDTH(B_WIDTH)
        ) branch_unit_inst (
            .sample(sample),
            .expected(expected[b]),
            .symbol(branch_symbol(b)),
            .source(states[SRC]),
            .candidate(cand[DST][SLOT])
        );
    end

    for (genvar s = 0; s < NUM_STATES; s++) begin : gen_state
        // only state 0 starts cheap, matching the +1 preamble.
        state_unit #(
            .RESET_ENERGY(s == 0 ? energy_t'(0) : INIT_ENERGY)
        ) state_unit_inst (
            .clk(clk),
            .reset(reset),
            .sample_valid(sample_valid),
            .cand_a(cand[s][0]),
            .cand_b(cand[s][1]),
            .min_energy(min_energy),
            .state(states[s])
        );
    end

    survivor_select #(
        .H_DEPTH(H_DEPTH)
    ) survivor_select_inst (
        .clk(clk),
        .reset(reset),
        .sample_valid(sample_valid),
        .states(states),
        .min_energy(min_energy),
        .decision(decision),
        .decision_valid(decision_valid)
    );

endmodule

// ==== hdl/survivor_select.sv ====
`timescale 1ns/1ps

module survivor_select
    import viterbi_pkg::*;
#(
    parameter int H_DEPTH = 8
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       sample_valid,
    input  state_rec_t states [NUM_STATES],
    output energy_t    min_energy,
    output symbol_t    decision,
    output logic       decision_valid
);

    localparam int COUNT_WIDTH = $clog2(H_MAX + 1);

    logic [STATE_BITS-1:0]  best;
    logic [COUNT_WIDTH-1:0] sample_count;
    logic                   warm;

    // lowest energy, lowest index on ties.
    always_comb begin
        best       = '0;
        min_energy = states[0].energy;
        for (int s = 1; s < NUM_STATES; s++) begin
            if (states[s].energy < min_energy) begin
                best       = STATE_BITS'(s);
                min_energy = states[s].energy;
            end
        end
    end

    // enough samples seen to fill the history.
    assign warm = (sample_count == COUNT_WIDTH'(H_DEPTH));

    always_ff @(posedge clk) begin
        if (reset) begin
            sample_count <= '0;
        end else if (sample_valid && !warm) begin
            sample_count <= sample_count + COUNT_WIDTH'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            decision       <= '0;
            decision_valid <= 1'b0;
        end else begin
            decision_valid <= sample_valid && warm;
            if (sample_valid) begin
                // oldest symbol of the best path.
                decision <= states[best].history[H_DEPTH-1];
            end
        end
    end

endmodule

// ==== hdl/state_unit.sv ====
`timescale 1ns/1ps

module state_unit
    import viterbi_pkg::*;
#(
    parameter energy_t RESET_ENERGY = INIT_ENERGY
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       sample_valid,
    input  state_rec_t cand_a,
    input  state_rec_t cand_b,
    input  energy_t    min_energy,
    output state_rec_t state
);

    state_rec_t survivor;
    state_rec_t next_state;

    // add-compare-select, ties go to the lower branch in cand_a.
    always_comb begin
        if (cand_b.energy < cand_a.energy) begin
            survivor = cand_b;
        end else begin
            survivor = cand_a;
        end
    end

    // subtract the old minimum so metrics stay bounded.
    always_comb begin
        next_state.energy  = survivor.energy - min_energy;
        next_state.history = survivor.history;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state.energy  <= RESET_ENERGY;
            state.history <= {H_MAX{SYM_POS}};
        end else if (sample_valid) begin
            state <= next_state;
        end
    end

endmodule

// ==== hdl/branch_unit.sv ====
`timescale 1ns/1ps

module branch_unit
    import viterbi_pkg::*;
#(
    parameter int B_WIDTH = 8
) (
    input  logic signed [B_WIDTH-1:0] sample,
    input  expect_t                   expected,
    input  symbol_t                   symbol,
    input  state_rec_t                source,
    output state_rec_t                candidate
);

    localparam int DIFF_WIDTH = (B_WIDTH > EXP_WIDTH ? B_WIDTH : EXP_WIDTH) + 1;
    localparam int SQ_WIDTH   = 2 * DIFF_WIDTH;

    logic signed [DIFF_WIDTH-1:0] diff;
    logic [DIFF_WIDTH-1:0]        mag;
    logic [SQ_WIDTH-1:0]          square;
    logic [SQ_WIDTH:0]            sum;

    assign diff   = DIFF_WIDTH'(sample) - DIFF_WIDTH'(expected);
    assign mag    = diff[DIFF_WIDTH-1] ? -diff : diff;
    assign square = mag * mag;
    assign sum    = (SQ_WIDTH + 1)'(source.energy) + (SQ_WIDTH + 1)'(square);

    always_comb begin
        // clamp at all ones.
        if (|sum[SQ_WIDTH:ENERGY_WIDTH]) begin
            candidate.energy = ENERGY_MAX;
        end else begin
            candidate.energy = sum[ENERGY_WIDTH-1:0];
        end
        candidate.history = {source.history[H_MAX-2:0], symbol};
    end

endmodule

// ==== hdl/expectation_table.sv ====
`timescale 1ns/1ps

module expectation_table
    import viterbi_pkg::*;
(
    input  logic                        clk,
    input  logic                        reset,
    input  logic signed [TAP_WIDTH-1:0] est_channel [CHAN_TAPS],
    input  logic                        update,
    output expect_t                     expected [NUM_BRANCHES]
);

    expect_t next_expected [NUM_BRANCHES];

    always_comb begin
        logic [CHAN_TAPS-1:0] neg;
        logic [1:0]           src;
        symbol_t              sym;
        expect_t              acc;
        for (int b = 0; b < NUM_BRANCHES; b++) begin
            src = branch_source(b);
            sym = branch_symbol(b);
            // tap 0 sees the new symbol, taps 1 and 2 the older ones.
            neg[0] = sym[1];
            neg[1] = src[1];
            neg[2] = src[0];
            acc = '0;
            for (int t = 0; t < CHAN_TAPS; t++) begin
                if (neg[t]) begin
                    acc = acc - expect_t'(est_channel[t]);
                end else begin
                    acc = acc + expect_t'(est_channel[t]);
                end
            end
            next_expected[b] = acc;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int b = 0; b < NUM_BRANCHES; b++) begin
                expected[b] <= '0;
            end
        end else if (update) begin
            expected <= next_expected;
        end
    end

endmodule

// ==== hdl/viterbi_pkg.sv ====
package viterbi_pkg;

    // trellis and datapath sizes.
    localparam int NUM_STATES   = 4;
    localparam int NUM_BRANCHES = 8;
    localparam int CHAN_TAPS    = 3;
    localparam int TAP_WIDTH    = 8;
    localparam int EXP_WIDTH    = 10;
    localparam int ENERGY_WIDTH = 16;
    localparam int H_MAX        = 16;
    localparam int STATE_BITS   = $clog2(NUM_STATES);

    typedef logic signed [1:0] symbol_t;
    typedef logic [ENERGY_WIDTH-1:0] energy_t;
    typedef logic signed [EXP_WIDTH-1:0] expect_t;

    // bit 1 of a symbol is set for -1.
    localparam symbol_t SYM_POS = 2'sb01;
    localparam symbol_t SYM_NEG = 2'sb11;

    localparam energy_t ENERGY_MAX = '1;

    // far above any metric reached during the +1 preamble.
    localparam energy_t INIT_ENERGY = 16'h2000;

    // history[0] is the newest symbol.
    typedef struct packed {
        energy_t             energy;
        symbol_t [H_MAX-1:0] history;
    } state_rec_t;

    // a branch index is {source state, new symbol bit}.
    function automatic logic [1:0] branch_source(input int branch);
        return branch[2:1];
    endfunction

    function automatic symbol_t branch_symbol(input int branch);
        return branch[0] ? SYM_NEG : SYM_POS;
    endfunction

    // new symbol becomes the most recent, source msb moves down.
    function automatic logic [1:0] branch_dest(input int branch);
        return {branch[0], branch[2]};
    endfunction

endpackage
